// ==== Bender.yml ====
package:
  name: peripheralBus

sources:
  - include_dirs:
      - include
    files:
      - hw/machinePkg.sv
      - hw/byteTo7Seg.sv
      - hw/sevenSegDecoder.sv
      - hw/dataRam.sv
      - hw/ledPort.sv
      - hw/readReturnMux.sv
      - hw/peripheralBus.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/peripheralBus_assert.sv
      - verif/peripheralBus_tb.sv

// ==== hw/byteTo7Seg.sv ====
module byteTo7Seg import machinePkg::*; (
    input  logic [7:0]  num,
    output segPattern_t disp
);

    always_comb begin
        case (num)
            8'd0:    disp = 8'b0111_1110;
            8'd1:    disp = 8'b0000_1100;
            8'd2:    disp = 8'b1011_0110;
            8'd3:    disp = 8'b1001_1110;
            8'd4:    disp = 8'b1100_1100;
            8'd5:    disp = 8'b1101_1010;
            8'd6:    disp = 8'b1111_1010;
            8'd7:    disp = 8'b0000_1110;
            8'd8:    disp = 8'b1111_1110;
            8'd9:    disp = 8'b1101_1110;
            8'd10:   disp = 8'b1110_1110; // Letter A.
            default: disp = 8'b0000_0000; // Anything else blanks the digit.
        endcase
    end

endmodule

// ==== hw/dataRam.sv ====
`include "machine_params.svh"

module dataRam import machinePkg::*; (
    input  logic        clk,
    input  busAddress_t address,
    input  logic [7:0]  databus,
    input  logic        writeEnable,
    input  logic        readEnable,
    output logic [7:0]  ramData
);

    localparam int AddrWidth = $clog2(`RAM_DEPTH);

    logic [7:0]           mem [`RAM_DEPTH];
    logic                 ramSel;
    logic [AddrWidth-1:0] index;

    assign ramSel = (address.fields.page == `RAM_PAGE);
    assign index  = address.fields.offset[AddrWidth-1:0];

    always_ff @(posedge clk) begin
        if (writeEnable && ramSel) begin
            mem[index] <= databus;
        end
    end

    // Read port holds its last byte between reads.
    always_ff @(posedge clk) begin
        if (readEnable && ramSel) begin
            ramData <= mem[index];
        end
    end

endmodule

// ==== hw/ledPort.sv ====
`include "machine_params.svh"

module ledPort import machinePkg::*; (
    input  logic        clk,
    input  logic        nrst,
    input  busAddress_t address,
    input  logic [7:0]  databus,
    input  logic        writeEnable,
    input  logic        readEnable,
    output logic [7:0]  leds,
    output logic [7:0]  ledData
);

    logic directHit;
    logic toggleHit;

    assign directHit = (address.word == `LED_ADDRESS);
    assign toggleHit = (address.word == `LED_ADDRESS + 16'd1);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            leds <= 8'h00;
        end else if (writeEnable) begin
            if (directHit) begin
                leds <= databus;
            end else if (toggleHit) begin
                leds <= leds ^ databus; // Set bits in databus flip the LED.
            end
        end
    end

    // Samples leds before a write landing at the same edge.
    always_ff @(posedge clk) begin
        if (readEnable && (directHit || toggleHit)) begin
            ledData <= leds;
        end
    end

endmodule

// ==== hw/machinePkg.sv ====
package machinePkg;

    // The same bus word seen whole or as page and offset bytes.
    typedef union packed {
        logic [15:0] word;
        struct packed {
            logic [7:0] page;
            logic [7:0] offset;
        } fields;
    } busAddress_t;

    typedef logic [7:0] segPattern_t; // Bit 0 is unused.

    typedef segPattern_t displayBank_t [0:7];

    typedef enum logic [1:0] {
        NONE = 2'd0,
        RAM  = 2'd1,
        LED  = 2'd2
    } readSource_t;

endpackage

// ==== hw/peripheralBus.sv ====
module peripheralBus import machinePkg::*; (
    input  logic         clk,
    input  logic         nrst,
    input  logic [7:0]   addressbusHigh,
    input  logic [7:0]   addressbusLow,
    input  logic [7:0]   databus,
    input  logic         writeEnable,
    input  logic         readEnable,
    output displayBank_t sevenSegs,
    output logic [7:0]   leds,
    output logic [7:0]   readData,
    output logic         readValid
);

    busAddress_t address;
    logic [7:0]  ramData;
    logic [7:0]  ledData;

    assign address.fields.page   = addressbusHigh;
    assign address.fields.offset = addressbusLow;

    // Each target decodes the address on its own.
    sevenSegDecoder displays (
        .clk         (clk),
        .nrst        (nrst),
        .address     (address),
        .databus     (databus),
        .writeEnable (writeEnable),
        .sevenSegs   (sevenSegs)
    );

    dataRam ram (
        .clk         (clk),
        .address     (address),
        .databus     (databus),
        .writeEnable (writeEnable),
        .readEnable  (readEnable),
        .ramData     (ramData)
    );

    ledPort ledOut (
        .clk         (clk),
        .nrst        (nrst),
        .address     (address),
        .databus     (databus),
        .writeEnable (writeEnable),
        .readEnable  (readEnable),
        .leds        (leds),
        .ledData     (ledData)
    );

    readReturnMux readMux (
        .clk        (clk),
        .nrst       (nrst),
        .address    (address),
        .readEnable (readEnable),
        .ramData    (ramData),
        .ledData    (ledData),
        .readData   (readData),
        .readValid  (readValid)
    );

endmodule

// ==== hw/readReturnMux.sv ====
`include "machine_params.svh"

module readReturnMux import machinePkg::*; (
    input  logic        clk,
    input  logic        nrst,
    input  busAddress_t address,
    input  logic        readEnable,
    input  logic [7:0]  ramData,
    input  logic [7:0]  ledData,
    output logic [7:0]  readData,
    output logic        readValid
);

    readSource_t source;
    readSource_t nextSource;
    logic [15:0] ledRel;

    assign ledRel = address.word - `LED_ADDRESS;

    always_comb begin
        if (address.fields.page == `RAM_PAGE) begin
            nextSource = RAM;
        end else if (ledRel[15:1] == 15'd0) begin
            nextSource = LED; // Direct and toggle addresses both read back.
        end else begin
            nextSource = NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            source    <= NONE;
            readValid <= 1'b0;
        end else begin
            readValid <= readEnable;
            if (readEnable) begin
                source <= nextSource;
            end
        end
    end

    always_comb begin
        case (source)
            RAM:     readData = ramData;
            LED:     readData = ledData;
            default: readData = 8'h00; // Unmapped and display reads give zero.
        endcase
    end

endmodule

// ==== hw/sevenSegDecoder.sv ====
`include "machine_params.svh"

module sevenSegDecoder import machinePkg::*; (
    input  logic         clk,
    input  logic         nrst,
    input  busAddress_t  address,
    input  logic [7:0]   databus,
    input  logic         writeEnable,
    output displayBank_t sevenSegs
);

    segPattern_t decodedData;
    logic [15:0] relAddress;
    logic        digitHit;
    logic [2:0]  digitSel;

    byteTo7Seg digitLookup (
        .num  (databus),
        .disp (decodedData)
    );

    // Offset from the first display register.
    assign relAddress = address.word - `DECODER_BASE_ADDRESS;

    // Only the low three bits may be set for a display hit.
    assign digitHit = writeEnable && (relAddress[15:3] == 13'd0);
    assign digitSel = relAddress[2:0];

    always_ff @(posedge clk) begin
        if (!nrst) begin
            sevenSegs <= '{default: '0};
        end else if (digitHit) begin
            sevenSegs[digitSel] <= decodedData; // Other digits keep their pattern.
        end
    end

endmodule

// ==== include/machine_params.svh ====
`ifndef MACHINE_PARAMS_SVH
`define MACHINE_PARAMS_SVH

// Display registers sit at base+0 through base+7.
`define DECODER_BASE_ADDRESS 16'hC000

// Direct LED write; the next address toggles bits.
`define LED_ADDRESS 16'hC010

`define RAM_PAGE 8'h00

`define RAM_DEPTH 256

`endif

// ==== peripheralBus.f ====
+incdir+include
hw/machinePkg.sv
hw/byteTo7Seg.sv
hw/sevenSegDecoder.sv
hw/dataRam.sv
hw/ledPort.sv
hw/readReturnMux.sv
hw/peripheralBus.sv
verif/peripheralBus_assert.sv
verif/peripheralBus_tb.sv

// ==== verif/peripheralBus_assert.sv ====
module peripheralBus_assert (
    input logic clk,
    input logic nrst,
    input logic readEnable,
    input logic readValid
);

    // Every read gets its valid pulse on the following cycle.
    validAfterRead: assert property (
        @(posedge clk) disable iff (!nrst)
        readEnable |=> readValid
    ) else $error("readValid did not follow a read by one cycle.");

    // No valid pulse appears without a read the cycle before.
    noSpuriousValid: assert property (
        @(posedge clk) disable iff (!nrst)
        !readEnable |=> !readValid
    ) else $error("readValid was high without a preceding read.");

    resetClearsValid: assert property (
        @(posedge clk)
        !nrst |=> !readValid
    ) else $error("readValid was high while reset was applied.");

endmodule

bind readReturnMux peripheralBus_assert readChecks (
    .clk        (clk),
    .nrst       (nrst),
    .readEnable (readEnable),
    .readValid  (readValid)
);

// ==== verif/peripheralBus_tb.sv ====
`include "machine_params.svh"

module peripheralBus_tb import machinePkg::*; ();

    localparam int ClockPeriod    = 20;
    localparam int ResetCycles    = 4;
    localparam int RandomCycles   = 2000;
    localparam int DirectedCycles = 40;
    localparam int TimeoutLimit   = (RandomCycles + DirectedCycles + ResetCycles) * ClockPeriod
                                    + 1000;

    logic         clk;
    logic         nrst;
    logic [7:0]   addressbusHigh;
    logic [7:0]   addressbusLow;
    logic [7:0]   databus;
    logic         writeEnable;
    logic         readEnable;
    displayBank_t sevenSegs;
    logic [7:0]   leds;
    logic [7:0]   readData;
    logic         readValid;

    logic [31:0]  seed;

    logic [7:0]   modelRam [256];
    bit           ramWritten [256];
    segPattern_t  modelSegs [8];
    logic [7:0]   modelLeds;
    logic         expValid;  // A read is in flight and its result is due next cycle.
    logic         expCheck;  // False for reads of RAM bytes that were never written.
    logic [7:0]   expData;

    peripheralBus dut (
        .clk            (clk),
        .nrst           (nrst),
        .addressbusHigh (addressbusHigh),
        .addressbusLow  (addressbusLow),
        .databus        (databus),
        .writeEnable    (writeEnable),
        .readEnable     (readEnable),
        .sevenSegs      (sevenSegs),
        .leds           (leds),
        .readData       (readData),
        .readValid      (readValid)
    );

    always #(ClockPeriod / 2) clk = ~clk;

    function automatic logic [31:0] nextRandom();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Segment table of the display, with the letter A for ten.
    function automatic segPattern_t digitPattern(input logic [7:0] value);
        case (value)
            8'd0:    return 8'h7E;
            8'd1:    return 8'h0C;
            8'd2:    return 8'hB6;
            8'd3:    return 8'h9E;
            8'd4:    return 8'hCC;
            8'd5:    return 8'hDA;
            8'd6:    return 8'hFA;
            8'd7:    return 8'h0E;
            8'd8:    return 8'hFE;
            8'd9:    return 8'hDE;
            8'd10:   return 8'hEE;
            default: return 8'h00;
        endcase
    endfunction

    // Mostly mapped addresses; the last group may land anywhere.
    function automatic logic [15:0] pickAddress();
        logic [31:0] r;
        r = nextRandom();
        if (r[31:28] < 4'd6) begin
            return {`RAM_PAGE, r[20] ? {3'b000, r[19:15]} : r[23:16]};
        end else if (r[31:28] < 4'd9) begin
            return `DECODER_BASE_ADDRESS + {13'd0, r[18:16]};
        end else if (r[31:28] < 4'd12) begin
            return `LED_ADDRESS + {15'd0, r[16]};
        end
        return r[23:8];
    endfunction

    function automatic logic [7:0] pickData();
        logic [31:0] r;
        r = nextRandom();
        return r[31] ? {4'd0, r[27:24]} : r[23:16]; // Small values hit the digit table.
    endfunction

    task automatic checkValue(input string name, input logic [7:0] got,
                              input logic [7:0] expected);
        if (got !== expected) begin
            $display("mismatch time=%0t %s got=%h expected=%h", $time, name, got, expected);
            $display("** FAIL **");
            $fatal(1, "Stopping at the first error.");
        end
    endtask

    task automatic checkOutputs();
        for (int i = 0; i < 8; i++) begin
            checkValue($sformatf("sevenSegs[%0d]", i), sevenSegs[i], modelSegs[i]);
        end
        checkValue("leds", leds, modelLeds);
        checkValue("readValid", {7'd0, readValid}, {7'd0, expValid});
        if (expValid && expCheck) begin
            checkValue("readData", readData, expData);
        end
    endtask

    // Predicts the outputs after the next rising edge.
    task automatic applyModel(input logic we, input logic re, input logic [15:0] addr,
                              input logic [7:0] data);
        logic [7:0] page;
        logic [7:0] offset;
        page     = addr[15:8];
        offset   = addr[7:0];
        expValid = re;
        expCheck = 1'b0;
        if (re) begin
            expCheck = 1'b1;
            expData  = 8'h00;
            if (page == `RAM_PAGE) begin
                expData  = modelRam[offset];
                expCheck = ramWritten[offset];
            end else if (addr == `LED_ADDRESS || addr == `LED_ADDRESS + 16'd1) begin
                expData = modelLeds; // Value before any write at the same edge.
            end
        end
        if (we) begin
            if (page == `RAM_PAGE) begin
                modelRam[offset]   = data;
                ramWritten[offset] = 1'b1;
            end else if (addr >= `DECODER_BASE_ADDRESS &&
                         addr <= `DECODER_BASE_ADDRESS + 16'd7) begin
                modelSegs[addr[2:0]] = digitPattern(data);
            end else if (addr == `LED_ADDRESS) begin
                modelLeds = data;
            end else if (addr == `LED_ADDRESS + 16'd1) begin
                modelLeds = modelLeds ^ data;
            end
        end
    endtask

    task automatic busCycle(input logic we, input logic re, input logic [15:0] addr,
                            input logic [7:0] data);
        @(negedge clk);
        checkOutputs();
        writeEnable    = we;
        readEnable     = re;
        addressbusHigh = addr[15:8];
        addressbusLow  = addr[7:0];
        databus        = data;
        applyModel(we, re, addr, data);
    endtask

    task automatic writeBus(input logic [15:0] addr, input logic [7:0] data);
        busCycle(1'b1, 1'b0, addr, data);
    endtask

    task automatic readBus(input logic [15:0] addr);
        busCycle(1'b0, 1'b1, addr, 8'h00);
    endtask

    task automatic idleBus();
        busCycle(1'b0, 1'b0, 16'h0000, 8'h00);
    endtask

    initial begin
        #(TimeoutLimit);
        $display("Timeout: the run did not finish within its cycle budget.");
        $display("** FAIL **");
        $fatal(1, "Watchdog expired.");
    end

    initial begin
        logic [31:0] r;
        logic [15:0] addr;
        logic [7:0]  data;
        clk            = 1'b0;
        nrst           = 1'b0;
        addressbusHigh = 8'h00;
        addressbusLow  = 8'h00;
        databus        = 8'h00;
        writeEnable    = 1'b0;
        readEnable     = 1'b0;
        seed           = 32'h9d6a;
        modelLeds      = 8'h00;
        expValid       = 1'b0;
        expCheck       = 1'b0;
        expData        = 8'h00;
        for (int i = 0; i < 8; i++) begin
            modelSegs[i] = 8'h00;
        end
        for (int i = 0; i < 256; i++) begin
            ramWritten[i] = 1'b0;
        end
        repeat (ResetCycles) @(negedge clk);
        nrst = 1'b1;
        checkOutputs();

        for (int i = 0; i < 8; i++) begin
            writeBus(`DECODER_BASE_ADDRESS + 16'(i), 8'(i + 2));
        end
        writeBus(`DECODER_BASE_ADDRESS + 16'd3, 8'd10);
        writeBus(`DECODER_BASE_ADDRESS + 16'd5, 8'd200); // Blanks the digit.
        writeBus(`LED_ADDRESS, 8'hA5);
        writeBus(`LED_ADDRESS + 16'd1, 8'h0F);
        readBus(`LED_ADDRESS);
        readBus(`LED_ADDRESS + 16'd1);
        writeBus(16'h0010, 8'h3C);
        writeBus(16'h0011, 8'hC3);
        writeBus(16'h00FF, 8'h5A);
        readBus(16'h0010);
        readBus(16'h00FF);
        readBus(16'h0011);
        readBus(16'h0010);
        readBus(`LED_ADDRESS);
        readBus(16'h1234);
        readBus(`DECODER_BASE_ADDRESS + 16'd2);
        writeBus(`DECODER_BASE_ADDRESS + 16'd8, 8'd4);
        writeBus(16'h1211, 8'h77); // Same offset as a written RAM byte, other page.
        readBus(16'h0011);
        idleBus();

        for (int n = 0; n < RandomCycles; n++) begin
            addr = pickAddress();
            data = pickData();
            r    = nextRandom();
            if (r[31:30] < 2'd2) begin
                writeBus(addr, data);
            end else if (r[31:30] == 2'd2) begin
                readBus(addr);
            end else begin
                idleBus();
            end
        end
        idleBus();
        idleBus();

        $display("** PASS **");
        $finish;
    end

endmodule
